/* verilog/dcache_defines.svh */
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// Cache geometry
`define DC_WAYS    4
`define DC_SETS    16
`define DC_WORDS   16

// Address split
`define DC_TAG_W   22
`define DC_IDX_W   4
`define DC_WOFF_W  4
`define DC_WAY_W   2

// Bus width, CPU and memory sides alike
`define DC_DATA_W  32

`endif

/* verilog/cache_addr_pkg.sv */
`include "dcache_defines.svh"

package cache_addr_pkg;

  localparam int LINE_W = `DC_TAG_W + `DC_IDX_W;

  typedef logic [`DC_WAY_W-1:0]  way_t;
  typedef logic [`DC_IDX_W-1:0]  idx_t;
  typedef logic [`DC_WOFF_W-1:0] woff_t;
  typedef logic [`DC_TAG_W-1:0]  tag_t;

  // Lookup split of a byte address
  typedef struct packed {
    tag_t        tag;
    idx_t        idx;
    woff_t       word;
    logic [1:0]  byte_off;
  } addr_lookup_t;

  // Line number and byte inside the line, for bursts
  typedef struct packed {
    logic [LINE_W-1:0]    line_no;
    logic [31-LINE_W:0]   off;
  } addr_line_t;

  typedef union packed {
    addr_lookup_t lk;
    addr_line_t   ln;
  } dcache_addr_u;

endpackage

/* verilog/cache_ctrl_pkg.sv */
package cache_ctrl_pkg;

  // Request FSM
  typedef enum logic [2:0] {
    DC_IDLE      = 3'd0,
    DC_LOOKUP    = 3'd1,
    DC_WRITEBACK = 3'd2,
    DC_REFILL    = 3'd3,
    DC_RESPOND   = 3'd4
  } dc_state_e;

  // Command from the controller to the memory port, held for the whole burst
  typedef enum logic [1:0] {
    BURST_NONE   = 2'd0,
    BURST_WB     = 2'd1,
    BURST_REFILL = 2'd2
  } burst_cmd_e;

endpackage

/* verilog/dcache_data_array.sv */
`timescale 1ns/1ns
`include "dcache_defines.svh"

module dcache_data_array (
  input  logic                     clk,
  // CPU port
  input  cache_addr_pkg::idx_t     cpu_idx,
  input  cache_addr_pkg::way_t     cpu_way,
  input  cache_addr_pkg::woff_t    cpu_word,
  input  logic [`DC_DATA_W/8-1:0]  cpu_we,
  input  logic [`DC_DATA_W-1:0]    cpu_wdata,
  output logic [`DC_DATA_W-1:0]    cpu_rdata,
  // Memory-port port
  input  cache_addr_pkg::idx_t     mp_idx,
  input  cache_addr_pkg::way_t     mp_way,
  input  cache_addr_pkg::woff_t    mp_word,
  input  logic                     mp_we,
  input  logic [`DC_DATA_W-1:0]    mp_wdata,
  output logic [`DC_DATA_W-1:0]    mp_rdata
);

  localparam int DEPTH = `DC_SETS * `DC_WORDS;

  logic [`DC_DATA_W-1:0] mem      [`DC_WAYS][DEPTH];
  logic [`DC_DATA_W-1:0] cpu_rd_q [`DC_WAYS];

  always_ff @(posedge clk)
  begin
    for (int b = 0; b < `DC_DATA_W/8; b++)
      if (cpu_we[b])
        mem[cpu_way][{cpu_idx, cpu_word}][8*b +: 8] <= cpu_wdata[8*b +: 8];
    if (mp_we)
      mem[mp_way][{mp_idx, mp_word}] <= mp_wdata;   // Whole words only
  end

  // All ways read at once, the hit way picks one in the next cycle
  always_ff @(posedge clk)
  begin
    for (int w = 0; w < `DC_WAYS; w++)
      cpu_rd_q[w] <= mem[w][{cpu_idx, cpu_word}];
    mp_rdata <= mem[mp_way][{mp_idx, mp_word}];
  end

  assign cpu_rdata = cpu_rd_q[cpu_way];

endmodule

/* verilog/dcache_tag_array.sv */
`timescale 1ns/1ns
`include "dcache_defines.svh"

module dcache_tag_array (
  input  logic                  clk,
  input  logic                  rst,
  input  cache_addr_pkg::idx_t  lk_idx,
  input  cache_addr_pkg::tag_t  lk_tag,
  output logic                  hit,
  output cache_addr_pkg::way_t  hit_way,
  input  cache_addr_pkg::way_t  victim_way,
  output logic                  victim_dirty,
  output cache_addr_pkg::tag_t  victim_tag,
  output logic [`DC_WAYS-1:0]   valid_mask,
  input  logic                  set_dirty,
  input  cache_addr_pkg::way_t  dirty_way,
  input  logic                  fill,
  input  cache_addr_pkg::way_t  fill_way,
  input  cache_addr_pkg::tag_t  fill_tag
);
  import cache_addr_pkg::*;

  tag_t                tags  [`DC_WAYS][`DC_SETS];
  logic [`DC_SETS-1:0] valid [`DC_WAYS];
  logic [`DC_SETS-1:0] dirty [`DC_WAYS];
  tag_t                tag_q [`DC_WAYS];
  logic [`DC_WAYS-1:0] dirty_q;
  logic [`DC_WAYS-1:0] match;

  // Tag storage, read registered one cycle after lk_idx
  always_ff @(posedge clk)
  begin
    if (fill)
      tags[fill_way][lk_idx] <= fill_tag;
    for (int w = 0; w < `DC_WAYS; w++)
      tag_q[w] <= tags[w][lk_idx];
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int w = 0; w < `DC_WAYS; w++)
      begin
        valid[w] <= '0;
        dirty[w] <= '0;
      end
      valid_mask <= '0;
      dirty_q    <= '0;
    end
    else
    begin
      if (fill)
      begin
        valid[fill_way][lk_idx] <= 1'b1;
        dirty[fill_way][lk_idx] <= 1'b0;   // Fresh line from memory
      end
      if (set_dirty)
        dirty[dirty_way][lk_idx] <= 1'b1;
      for (int w = 0; w < `DC_WAYS; w++)
      begin
        valid_mask[w] <= valid[w][lk_idx];
        dirty_q[w]    <= dirty[w][lk_idx];
      end
    end
  end

  // Parallel compare over all ways
  always_comb
  begin
    hit_way = '0;
    for (int w = 0; w < `DC_WAYS; w++)
    begin
      match[w] = valid_mask[w] && (tag_q[w] == lk_tag);
      if (match[w])
        hit_way = way_t'(w);
    end
    hit = |match;
  end

  assign victim_dirty = valid_mask[victim_way] & dirty_q[victim_way];
  assign victim_tag   = tag_q[victim_way];   // Forms the write-back line address

endmodule

/* verilog/dcache_lru.sv */
`timescale 1ns/1ns
`include "dcache_defines.svh"

module dcache_lru (
  input  logic                 clk,
  input  logic                 rst,
  input  cache_addr_pkg::idx_t idx,
  input  logic [`DC_WAYS-1:0]  valid_mask,
  input  logic                 touch,
  input  cache_addr_pkg::way_t touch_way,
  output cache_addr_pkg::way_t victim_way
);
  import cache_addr_pkg::*;

  // 0 is most recent, `DC_WAYS-1 is oldest; each set holds a permutation
  logic [`DC_WAY_W-1:0] age [`DC_SETS][`DC_WAYS];

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int s = 0; s < `DC_SETS; s++)
        for (int w = 0; w < `DC_WAYS; w++)
          age[s][w] <= `DC_WAY_W'(w);
    end
    else if (touch)
    begin
      for (int w = 0; w < `DC_WAYS; w++)
      begin
        if (way_t'(w) == touch_way)
          age[idx][w] <= '0;
        else if (age[idx][w] < age[idx][touch_way])
          age[idx][w] <= age[idx][w] + `DC_WAY_W'(1);   // Younger ones slide back
      end
    end
  end

  // Invalid ways first, lowest number wins
  always_comb
  begin
    victim_way = '0;
    if (&valid_mask)
    begin
      for (int w = 1; w < `DC_WAYS; w++)
        if (age[idx][w] > age[idx][victim_way])
          victim_way = way_t'(w);
    end
    else
    begin
      for (int w = `DC_WAYS-1; w >= 0; w--)
        if (!valid_mask[w])
          victim_way = way_t'(w);
    end
  end

endmodule

/* verilog/dcache_ctrl.sv */
`timescale 1ns/1ns
`include "dcache_defines.svh"

module dcache_ctrl (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          req,
  input  logic                          we,
  input  logic [`DC_DATA_W/8-1:0]       wbyte,
  input  logic [`DC_DATA_W-1:0]         addr,
  input  logic [`DC_DATA_W-1:0]         wdata,
  output logic                          ok,
  output logic                          busy,
  output logic [`DC_DATA_W-1:0]         rdata,
  input  logic                          hit,
  input  cache_addr_pkg::way_t          hit_way,
  input  cache_addr_pkg::way_t          victim_way,
  input  logic                          victim_dirty,
  output cache_addr_pkg::idx_t          lk_idx,
  output cache_addr_pkg::tag_t          lk_tag,
  output logic                          touch,
  output cache_addr_pkg::way_t          touch_way,
  output logic [`DC_DATA_W/8-1:0]       cpu_we,
  output cache_addr_pkg::way_t          cpu_way,
  output cache_addr_pkg::woff_t         cpu_word,
  output logic [`DC_DATA_W-1:0]         cpu_wdata,
  input  logic [`DC_DATA_W-1:0]         rd_word,
  output logic                          set_dirty,
  output cache_ctrl_pkg::burst_cmd_e    burst_cmd,
  output cache_addr_pkg::way_t          burst_way,
  output cache_addr_pkg::dcache_addr_u  miss_addr,
  input  logic                          burst_done
);
  import cache_addr_pkg::*;
  import cache_ctrl_pkg::*;

  dc_state_e             state, state_nxt;
  dcache_addr_u          req_addr_q;
  logic                  we_q;
  logic [`DC_DATA_W/8-1:0] wbyte_q;
  logic [`DC_DATA_W-1:0] wdata_q;
  way_t                  victim_q;
  logic                  hit_ok;

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      state <= DC_IDLE;
    else
      state <= state_nxt;
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      DC_IDLE:      if (req) state_nxt = DC_LOOKUP;
      DC_LOOKUP:    state_nxt = DC_RESPOND;   // Arrays read this cycle
      DC_RESPOND:
        if (hit)
          state_nxt = DC_IDLE;
        else if (victim_dirty)
          state_nxt = DC_WRITEBACK;
        else
          state_nxt = DC_REFILL;
      DC_WRITEBACK: if (burst_done) state_nxt = DC_REFILL;
      DC_REFILL:    if (burst_done) state_nxt = DC_LOOKUP;   // Replay as a hit
      default:      state_nxt = DC_IDLE;
    endcase
  end

  // Request and victim capture
  always_ff @(posedge clk)
  begin
    if (state == DC_IDLE && req)
    begin
      req_addr_q <= addr;
      we_q       <= we;
      wbyte_q    <= wbyte;
      wdata_q    <= wdata;
    end
    if (state == DC_RESPOND && !hit)
      victim_q <= victim_way;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  assign hit_ok = (state == DC_RESPOND) && hit;

  assign ok        = hit_ok;
  assign busy      = (state != DC_IDLE);
  assign rdata     = rd_word;
  assign lk_idx    = req_addr_q.lk.idx;
  assign lk_tag    = req_addr_q.lk.tag;
  assign miss_addr = req_addr_q;
  assign touch     = hit_ok;
  assign touch_way = hit_way;
  assign cpu_way   = hit_way;
  assign cpu_word  = req_addr_q.lk.word;
  assign cpu_wdata = wdata_q;
  assign cpu_we    = (hit_ok && we_q) ? wbyte_q : '0;   // Byte merge in the array
  assign set_dirty = hit_ok && we_q;
  assign burst_way = victim_q;

  always_comb
  begin
    case (state)
      DC_WRITEBACK: burst_cmd = BURST_WB;
      DC_REFILL:    burst_cmd = BURST_REFILL;
      default:      burst_cmd = BURST_NONE;
    endcase
  end

endmodule

/* verilog/dcache_mem_port.sv */
`timescale 1ns/1ns
`include "dcache_defines.svh"

module dcache_mem_port (
  input  logic                          clk,
  input  logic                          rst,
  input  cache_ctrl_pkg::burst_cmd_e    burst_cmd,
  input  cache_addr_pkg::way_t          burst_way,
  input  cache_addr_pkg::dcache_addr_u  miss_addr,
  input  cache_addr_pkg::tag_t          victim_tag,
  output logic                          burst_done,
  // Data array side
  output cache_addr_pkg::idx_t          mp_idx,
  output cache_addr_pkg::way_t          mp_way,
  output cache_addr_pkg::woff_t         mp_word,
  output logic                          mp_we,
  output logic [`DC_DATA_W-1:0]         mp_wdata,
  input  logic [`DC_DATA_W-1:0]         mp_rdata,
  // Tag array side
  output logic                          fill,
  output cache_addr_pkg::way_t          fill_way,
  output cache_addr_pkg::tag_t          fill_tag,
  // Memory side
  output logic                          wr_valid,
  output logic [`DC_DATA_W-1:0]         wr_addr,
  output logic [`DC_DATA_W-1:0]         wr_data,
  input  logic                          wdata_ok,
  output logic                          rd_req,
  output logic [`DC_DATA_W-1:0]         rd_addr,
  input  logic                          rdata_ok,
  input  logic [`DC_DATA_W-1:0]         rdata_mem
);
  import cache_addr_pkg::*;
  import cache_ctrl_pkg::*;

  typedef enum logic [2:0] {
    MP_IDLE, MP_WB_PRE, MP_WB_RUN, MP_RF_RUN, MP_WB_END, MP_RF_END
  } mp_state_e;

  mp_state_e    st, st_nxt;
  woff_t        cnt;
  tag_t         wb_tag_q;
  dcache_addr_u wb_addr, rf_addr;
  logic         beat, last;

  assign beat = (st == MP_WB_RUN && wdata_ok) || (st == MP_RF_RUN && rdata_ok);
  assign last = beat && (cnt == woff_t'(`DC_WORDS-1));

  always_comb
  begin
    st_nxt = st;
    case (st)
      MP_IDLE:
        if (burst_cmd == BURST_WB)
          st_nxt = MP_WB_PRE;
        else if (burst_cmd == BURST_REFILL)
          st_nxt = MP_RF_RUN;
      MP_WB_PRE: st_nxt = MP_WB_RUN;   // First word read out of the array
      MP_WB_RUN: if (last) st_nxt = MP_WB_END;
      MP_RF_RUN: if (last) st_nxt = MP_RF_END;
      default:   st_nxt = MP_IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      st  <= MP_IDLE;
      cnt <= '0;
    end
    else
    begin
      st <= st_nxt;
      if (st == MP_IDLE)
        cnt <= '0;
      else if (beat)
        cnt <= cnt + woff_t'(1);
    end
  end

  // Victim tag held for the whole write-back
  always_ff @(posedge clk)
  begin
    if (st == MP_IDLE && burst_cmd == BURST_WB)
      wb_tag_q <= victim_tag;
  end

  // Read ahead one word on each accept
  always_comb
  begin
    case (st)
      MP_WB_RUN: mp_word = cnt + woff_t'(wdata_ok);
      MP_RF_RUN: mp_word = miss_addr.lk.word + cnt;   // Wraps modulo 16
      default:   mp_word = '0;
    endcase
  end

  always_comb
  begin
    wb_addr        = miss_addr;
    wb_addr.lk.tag = wb_tag_q;
    wb_addr.ln.off = '0;         // Line base
    rf_addr             = miss_addr;
    rf_addr.lk.byte_off = '0;    // Requested word
  end

  assign mp_idx     = miss_addr.lk.idx;
  assign mp_way     = burst_way;
  assign mp_we      = (st == MP_RF_RUN) && rdata_ok;
  assign mp_wdata   = rdata_mem;
  assign burst_done = (st == MP_WB_END) || (st == MP_RF_END);
  assign fill       = (st == MP_RF_END);
  assign fill_way   = burst_way;
  assign fill_tag   = miss_addr.lk.tag;
  assign wr_valid   = (st == MP_WB_RUN);
  assign wr_addr    = wb_addr;
  assign wr_data    = mp_rdata;
  assign rd_req     = (st == MP_RF_RUN);
  assign rd_addr    = rf_addr;

endmodule

/* verilog/dcache_top.sv */
`timescale 1ns/1ns
`include "dcache_defines.svh"

module dcache_top (
  input  logic                      clk,
  input  logic                      rst,
  // CPU side
  input  logic                      req,
  input  logic                      we,
  input  logic [`DC_DATA_W/8-1:0]   wbyte,
  input  logic [`DC_DATA_W-1:0]     addr,
  input  logic [`DC_DATA_W-1:0]     wdata,
  output logic                      ok,
  output logic                      busy,
  output logic [`DC_DATA_W-1:0]     rdata,
  // Write-back channel
  output logic                      wr_valid,
  output logic [`DC_DATA_W-1:0]     wr_addr,
  output logic [`DC_DATA_W-1:0]     wr_data,
  input  logic                      wdata_ok,
  // Refill channel
  output logic                      rd_req,
  output logic [`DC_DATA_W-1:0]     rd_addr,
  input  logic                      rdata_ok,
  input  logic [`DC_DATA_W-1:0]     rdata_mem
);
  import cache_addr_pkg::*;
  import cache_ctrl_pkg::*;

  logic                    hit, victim_dirty, touch, set_dirty, burst_done;
  logic                    mp_we, fill;
  way_t                    hit_way, victim_way, touch_way, cpu_way, burst_way;
  way_t                    mp_way, fill_way;
  idx_t                    lk_idx, mp_idx;
  tag_t                    lk_tag, victim_tag, fill_tag;
  woff_t                   cpu_word, mp_word;
  logic [`DC_WAYS-1:0]     valid_mask;
  logic [`DC_DATA_W/8-1:0] cpu_we;
  logic [`DC_DATA_W-1:0]   cpu_wdata, rd_word, mp_wdata, mp_rdata;
  burst_cmd_e              burst_cmd;
  dcache_addr_u            miss_addr;

  dcache_ctrl u_ctrl (
    .clk(clk), .rst(rst), .req(req), .we(we), .wbyte(wbyte), .addr(addr),
    .wdata(wdata), .ok(ok), .busy(busy), .rdata(rdata),
    .hit(hit), .hit_way(hit_way), .victim_way(victim_way),
    .victim_dirty(victim_dirty), .lk_idx(lk_idx), .lk_tag(lk_tag),
    .touch(touch), .touch_way(touch_way), .cpu_we(cpu_we), .cpu_way(cpu_way),
    .cpu_word(cpu_word), .cpu_wdata(cpu_wdata), .rd_word(rd_word),
    .set_dirty(set_dirty), .burst_cmd(burst_cmd), .burst_way(burst_way),
    .miss_addr(miss_addr), .burst_done(burst_done)
  );

  dcache_tag_array u_tags (
    .clk(clk), .rst(rst), .lk_idx(lk_idx), .lk_tag(lk_tag),
    .hit(hit), .hit_way(hit_way), .victim_way(victim_way),
    .victim_dirty(victim_dirty), .victim_tag(victim_tag),
    .valid_mask(valid_mask), .set_dirty(set_dirty), .dirty_way(cpu_way),
    .fill(fill), .fill_way(fill_way), .fill_tag(fill_tag)
  );

  dcache_lru u_lru (
    .clk(clk), .rst(rst), .idx(lk_idx), .valid_mask(valid_mask),
    .touch(touch), .touch_way(touch_way), .victim_way(victim_way)
  );

  dcache_data_array u_data (
    .clk(clk), .cpu_idx(lk_idx), .cpu_way(cpu_way), .cpu_word(cpu_word),
    .cpu_we(cpu_we), .cpu_wdata(cpu_wdata), .cpu_rdata(rd_word),
    .mp_idx(mp_idx), .mp_way(mp_way), .mp_word(mp_word), .mp_we(mp_we),
    .mp_wdata(mp_wdata), .mp_rdata(mp_rdata)
  );

  dcache_mem_port u_mem_port (
    .clk(clk), .rst(rst), .burst_cmd(burst_cmd), .burst_way(burst_way),
    .miss_addr(miss_addr), .victim_tag(victim_tag), .burst_done(burst_done),
    .mp_idx(mp_idx), .mp_way(mp_way), .mp_word(mp_word), .mp_we(mp_we),
    .mp_wdata(mp_wdata), .mp_rdata(mp_rdata),
    .fill(fill), .fill_way(fill_way), .fill_tag(fill_tag),
    .wr_valid(wr_valid), .wr_addr(wr_addr), .wr_data(wr_data), .wdata_ok(wdata_ok),
    .rd_req(rd_req), .rd_addr(rd_addr), .rdata_ok(rdata_ok), .rdata_mem(rdata_mem)
  );

endmodule

/* tests/dcache_asserts.sv */
`timescale 1ns/1ns

module dcache_asserts #(
  parameter bit CPU_SIDE = 1'b1
) (
  input logic        clk,
  input logic        rst,
  input logic        ok,
  input logic        req,
  input logic        busy,
  input logic        wr_valid,
  input logic [31:0] wr_addr,
  input logic        rd_req,
  input logic [31:0] rd_addr
);

  if (CPU_SIDE)
  begin : g_cpu
    a_ok_one_cycle: assert property (@(posedge clk) disable iff (rst) ok |=> !ok)
      else $error("ok held longer than one cycle");

    a_no_req_busy: assert property (@(posedge clk) disable iff (rst) req |-> !busy)
      else $error("req issued while busy");
  end
  else
  begin : g_mem
    a_channels_exclusive: assert property (@(posedge clk) disable iff (rst)
      !(wr_valid && rd_req))
      else $error("write-back and refill active together");

    a_wr_addr_stable: assert property (@(posedge clk) disable iff (rst)
      wr_valid |=> (!wr_valid || $stable(wr_addr)))
      else $error("wr_addr changed during write-back");

    a_rd_addr_stable: assert property (@(posedge clk) disable iff (rst)
      rd_req |=> (!rd_req || $stable(rd_addr)))
      else $error("rd_addr changed during refill");
  end

endmodule

// CPU side checks on the controller
bind dcache_ctrl dcache_asserts #(.CPU_SIDE(1'b1)) i_ctrl_asserts (
  .clk(clk), .rst(rst), .ok(ok), .req(req), .busy(busy),
  .wr_valid(1'b0), .wr_addr(32'd0), .rd_req(1'b0), .rd_addr(32'd0)
);

// Memory side checks on the burst sequencer
bind dcache_mem_port dcache_asserts #(.CPU_SIDE(1'b0)) i_mp_asserts (
  .clk(clk), .rst(rst), .ok(1'b0), .req(1'b0), .busy(1'b0),
  .wr_valid(wr_valid), .wr_addr(wr_addr), .rd_req(rd_req), .rd_addr(rd_addr)
);

/* tests/tb_dcache.sv */
`timescale 1ns/1ns

module tb_dcache;

  localparam int MAX_CYCLES = 60000;   // ~430 accesses at up to ~140 cycles each

  logic clk, rst, req, we, ok, busy, wr_valid, wdata_ok, rd_req, rdata_ok;
  logic [3:0]  wbyte;
  logic [31:0] addr, wdata, rdata, wr_addr, wr_data, rd_addr, rdata_mem;

  logic [31:0] mem    [4096];   // Backing memory
  logic [31:0] shadow [4096];   // CPU view of memory
  logic [21:0] m_tag   [16][4];
  logic        m_valid [16][4];
  logic        m_dirty [16][4];
  int          m_age   [16][4];

  int errors = 0, other_errors = 0, checks = 0;
  int cycles = 0, resp_cnt = 0, ok_cyc, req_cyc;
  int wcnt = 0, rcnt = 0, wb_beats, last_wb_cyc, first_rd_cyc;
  logic [31:0] wb_line;
  int rf_words[$];
  bit exp_rd_q[$];
  logic [31:0] exp_data_q[$];

  dcache_top i_dut (
    .clk(clk), .rst(rst), .req(req), .we(we), .wbyte(wbyte), .addr(addr),
    .wdata(wdata), .ok(ok), .busy(busy), .rdata(rdata),
    .wr_valid(wr_valid), .wr_addr(wr_addr), .wr_data(wr_data), .wdata_ok(wdata_ok),
    .rd_req(rd_req), .rd_addr(rd_addr), .rdata_ok(rdata_ok), .rdata_mem(rdata_mem)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] fill_word(input int i);
    logic [11:0] a;
    a = i[11:0];
    return {a ^ 12'h5a3, 8'hc7, ~a};
  endfunction

  // Expected word after a byte-enabled write
  function automatic logic [31:0] byte_merge(input logic [31:0] old, input logic [31:0] d,
                                             input logic [3:0] be);
    logic [31:0] r;
    r = old;
    for (int b = 0; b < 4; b++)
      if (be[b])
        r[8*b +: 8] = d[8*b +: 8];
    return r;
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // LRU model
  ////////////////////////////////////////////////////////////////////////////

  function automatic int find_way(input int s, input logic [21:0] t);
    for (int w = 0; w < 4; w++)
      if (m_valid[s][w] && m_tag[s][w] == t)
        return w;
    return -1;
  endfunction

  function automatic int pick_victim(input int s);
    int v;
    v = 0;
    for (int w = 0; w < 4; w++)
      if (!m_valid[s][w])
        return w;
    for (int w = 1; w < 4; w++)
      if (m_age[s][w] > m_age[s][v])
        v = w;
    return v;
  endfunction

  task automatic touch_way(input int s, input int t);
    int ref_age;
    ref_age = m_age[s][t];
    for (int w = 0; w < 4; w++)
      if (w == t)
        m_age[s][w] = 0;
      else if (m_age[s][w] < ref_age)
        m_age[s][w]++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Memory model, sampled at the edge and driven 1 ns later
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("Timeout: the run went past %0d cycles", MAX_CYCLES);
      $display("STATUS: FAIL");
      $finish;
    end
    else
    begin
      if (wr_valid && wdata_ok)
      begin
        check(wr_data, shadow[{wr_addr[13:6], wcnt[3:0]}], "write-back word");
        mem[{wr_addr[13:6], wcnt[3:0]}] = wr_data;
        wb_line = wr_addr;
        wb_beats++;
        last_wb_cyc = cycles;
        wcnt++;
      end
      if (!wr_valid)
        wcnt = 0;
      if (rd_req && rdata_ok)
      begin
        if (rf_words.size() == 0)
          first_rd_cyc = cycles;
        rf_words.push_back(int'(4'(rd_addr[5:2] + rcnt[3:0])));
        rcnt++;
      end
      if (!rd_req)
        rcnt = 0;
      #1;
      wdata_ok = wr_valid && ($urandom % 4 != 0);
      rdata_ok = rd_req && ($urandom % 3 != 0);
      rdata_mem = mem[{rd_addr[13:6], rd_addr[5:2] + rcnt[3:0]}];
    end
  end

  // Response compare
  always @(posedge clk)
  begin
    if (!rst && ok)
    begin
      if (exp_rd_q.size() == 0)
      begin
        other_errors++;
        $display("ok seen at %0t with no request outstanding", $time);
      end
      else if (exp_rd_q.pop_front())
        check(rdata, exp_data_q.pop_front(), "read data");
      else
        void'(exp_data_q.pop_front());
      ok_cyc = cycles;
      resp_cnt++;
    end
  end

  task automatic access(input bit wr, input logic [3:0] be, input logic [31:0] a,
                        input logic [31:0] d);
    int s, way, vic, start;
    bit exp_wb;
    logic [31:0] exp_line;
    s = a[9:6];
    way = find_way(s, a[31:10]);
    vic = pick_victim(s);
    exp_wb = (way < 0) && m_valid[s][vic] && m_dirty[s][vic];
    exp_line = {m_tag[s][vic], a[9:6], 6'd0};
    wb_beats = 0;
    rf_words.delete();
    exp_rd_q.push_back(!wr);
    exp_data_q.push_back(shadow[a[13:2]]);
    if (wr)
      shadow[a[13:2]] = byte_merge(shadow[a[13:2]], d, be);
    start = resp_cnt;
    req = 1'b1;
    we = wr;
    wbyte = be;
    addr = a;
    wdata = d;
    req_cyc = cycles;
    @(posedge clk);
    #1;
    req = 1'b0;
    do
    begin
      check(busy, 1, "busy while request pending");
      @(posedge clk);
      #1;
    end
    while (resp_cnt == start);
    check(busy, 0, "busy after ok");
    if (way >= 0)
      check(ok_cyc - req_cyc, 2, "hit latency");
    else
    begin
      check(ok_cyc - req_cyc > 2, 1, "miss latency");
      check(rf_words.size(), 16, "refill beats");
      for (int k = 0; k < rf_words.size(); k++)
        check(rf_words[k], (a[5:2] + k) % 16, "refill word order");
      m_tag[s][vic] = a[31:10];
      m_valid[s][vic] = 1'b1;
      m_dirty[s][vic] = 1'b0;
      way = vic;
    end
    check(wb_beats, exp_wb ? 16 : 0, "write-back beats");
    if (exp_wb)
    begin
      check(wb_line, exp_line, "write-back line");
      check(last_wb_cyc < first_rd_cyc, 1, "write-back before refill");
    end
    touch_way(s, way);
    if (wr)
      m_dirty[s][way] = 1'b1;
  endtask

  function automatic logic [31:0] make_addr(input int t, input int s, input int w);
    return (t << 10) | (s << 6) | (w << 2);
  endfunction

  initial
  begin
    void'($urandom(32'hd267ed3c));
    rst = 1'b1;
    {req, we, wdata_ok, rdata_ok} = '0;
    wbyte = '0;
    addr = '0;
    wdata = '0;
    rdata_mem = '0;
    for (int i = 0; i < 4096; i++)
    begin
      mem[i] = fill_word(i);
      shadow[i] = fill_word(i);
    end
    for (int s = 0; s < 16; s++)
      for (int w = 0; w < 4; w++)
      begin
        m_valid[s][w] = 1'b0;
        m_dirty[s][w] = 1'b0;
        m_age[s][w] = w;
        m_tag[s][w] = '0;
      end
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    check({ok, busy, wr_valid, rd_req}, 4'b0000, "idle outputs after reset");

    access(0, 4'h0, make_addr(0, 2, 7), 0);          // Cold miss, wrapping refill
    access(0, 4'h0, make_addr(0, 2, 3), 0);          // Hit on the same line
    access(1, 4'b0101, make_addr(0, 2, 3), 32'h11223344);
    access(0, 4'h0, make_addr(0, 2, 3), 0);
    access(1, 4'b1000, make_addr(3, 4, 12), 32'haabbccdd);   // Write miss
    access(0, 4'h0, make_addr(3, 4, 12), 0);

    // Five tags in set 5 force a dirty eviction
    for (int t = 1; t <= 4; t++)
      access(1, 4'hf, make_addr(t, 5, t), 32'h0 + t * 32'h01010101);
    access(0, 4'h0, make_addr(5, 5, 0), 0);
    check(wb_line, make_addr(1, 5, 0), "evicted line in set 5");

    // LRU order in set 9
    for (int t = 4; t <= 7; t++)
      access(0, 4'h0, make_addr(t, 9, 1), 0);
    access(1, 4'hf, make_addr(6, 9, 2), 32'h66);
    access(1, 4'hf, make_addr(4, 9, 2), 32'h44);
    access(1, 4'hf, make_addr(7, 9, 2), 32'h77);
    access(1, 4'hf, make_addr(5, 9, 2), 32'h55);
    access(0, 4'h0, make_addr(8, 9, 9), 0);
    check(wb_line, make_addr(6, 9, 0), "evicted line in set 9");

    for (int n = 0; n < 400; n++)
      access($urandom % 2, 4'($urandom), make_addr($urandom % 6, $urandom % 2,
             $urandom % 16), $urandom);

    $display("Checks: %0d, mismatches: %0d, other errors: %0d", checks, errors,
             other_errors);
    if (errors == 0 && other_errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

/* flist.f */
+incdir+verilog
verilog/cache_addr_pkg.sv
verilog/cache_ctrl_pkg.sv
verilog/dcache_data_array.sv
verilog/dcache_tag_array.sv
verilog/dcache_lru.sv
verilog/dcache_ctrl.sv
verilog/dcache_mem_port.sv
verilog/dcache_top.sv
tests/dcache_asserts.sv
tests/tb_dcache.sv

/* Makefile */
# Verilator simulation of the data cache

VERILATOR ?= verilator
TOP       ?= tb_dcache
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
